// File: logic/dspPkg.sv
package dspPkg;

	localparam int wordW = 32;
	localparam int accW = 48;
	localparam int prgDepth = 256;
	localparam int bankDepth = 64;
	localparam int bankCount = 4;
	localparam int loopW = 12;
	localparam int prgAddrW = $clog2(prgDepth);
	localparam int bankAddrW = $clog2(bankDepth);

	// Instruction class in bits 31:30
	localparam logic [1:0] clsOp = 2'b00;
	localparam logic [1:0] clsMvi = 2'b10;
	localparam logic [1:0] clsCtl = 2'b11;

	localparam logic [3:0] aluNop = 4'h0;
	localparam logic [3:0] aluAnd = 4'h1;
	localparam logic [3:0] aluOr = 4'h2;
	localparam logic [3:0] aluXor = 4'h3;
	localparam logic [3:0] aluAdd = 4'h4;
	localparam logic [3:0] aluSub = 4'h5;
	localparam logic [3:0] aluAd2 = 4'h6;
	localparam logic [3:0] aluSr = 4'h8;
	localparam logic [3:0] aluRr = 4'h9;
	localparam logic [3:0] aluSl = 4'hA;
	localparam logic [3:0] aluRl = 4'hB;
	localparam logic [3:0] aluRl8 = 4'hF;

	// D1 and move-immediate destinations, banks and counters count up from base
	localparam logic [3:0] dstRam0 = 4'h0;
	localparam logic [3:0] dstRx = 4'h4;
	localparam logic [3:0] dstP = 4'h5;
	localparam logic [3:0] dstPc = 4'h8;
	localparam logic [3:0] dstLop = 4'hA;
	localparam logic [3:0] dstTop = 4'hB;
	localparam logic [3:0] dstCt0 = 4'hC;

	localparam logic [2:0] srcImm = 3'd0;
	localparam logic [2:0] srcAluL = 3'd1;
	localparam logic [2:0] srcAluH = 3'd2;
	localparam logic [2:0] srcRam0 = 3'd4;

	localparam logic [1:0] xNone = 2'd0;
	localparam logic [1:0] xRx = 2'd1;
	localparam logic [1:0] xPRam = 2'd2;
	localparam logic [1:0] xPMul = 2'd3;

	localparam logic [2:0] yNone = 3'd0;
	localparam logic [2:0] yRy = 3'd1;
	localparam logic [2:0] yClrAc = 3'd2;
	localparam logic [2:0] yAcAlu = 3'd3;
	localparam logic [2:0] yAcRam = 3'd4;

	localparam logic [3:0] kindJmp = 4'd0;
	localparam logic [3:0] kindLps = 4'd1;
	localparam logic [3:0] kindBtm = 4'd2;
	localparam logic [3:0] kindEnd = 4'd3;
	localparam logic [3:0] kindEndi = 4'd4;

	localparam logic [1:0] regCtl = 2'd0;
	localparam logic [1:0] regPrg = 2'd1;
	localparam logic [1:0] regDataAddr = 2'd2;
	localparam logic [1:0] regData = 2'd3;

	localparam int statS = 22;
	localparam int statZ = 21;
	localparam int statC = 20;
	localparam int statE = 18;
	localparam int statEx = 16;
	localparam int ctlStep = 17;
	localparam int ctlLoadPc = 15;

	typedef struct packed {
		logic [1:0] cls;
		logic [3:0] aluOp;
		logic [1:0] xOp;
		logic [1:0] xSrc;
		logic [2:0] yOp;
		logic [1:0] ySrc;
		logic       d1En;
		logic [2:0] d1Src;
		logic [3:0] d1Dst;
		logic [8:0] d1Imm;
	} dspOpCmd;

	// sub is the kind for jump/loop/end and the destination for move-immediate
	typedef struct packed {
		logic [1:0]  cls;
		logic [3:0]  sub;
		logic        condSense;
		logic [3:0]  condMask;
		logic [12:0] immMid;
		logic [7:0]  target;
	} dspCtlCmd;

	typedef union packed {
		dspOpCmd  opView;
		dspCtlCmd ctlView;
	} dspInstr;

	// True when the word sends D1 or a move-immediate to dst
	function automatic logic d1Write(dspInstr i, logic [3:0] dst);
		return (i.opView.cls == clsOp && i.opView.d1En && i.opView.d1Dst == dst) ||
			(i.ctlView.cls == clsMvi && i.ctlView.sub == dst);
	endfunction

	// 25-bit move-immediate spans condMask, immMid and target
	function automatic logic [wordW-1:0] mviImm(dspInstr i);
		logic [24:0] imm;
		imm = {i.ctlView.condMask, i.ctlView.immMid, i.ctlView.target};
		return {{(wordW - 25){imm[24]}}, imm};
	endfunction

endpackage

// File: logic/dspRam.sv
module dspRam #(
	parameter int addrW = 8,
	parameter int dataW = 32
) (
	input  logic             CLK,
	input  logic [addrW-1:0] addr,
	input  logic [dataW-1:0] wrData,
	input  logic             wrEn,
	output logic [dataW-1:0] rdData
);

	logic [dataW-1:0] mem [2**addrW];

	always_ff @(posedge CLK) begin
		if (wrEn) begin
			mem[addr] <= wrData;
		end
	end

	assign rdData = mem[addr];

	assert property (@(posedge CLK) wrEn |-> !$isunknown(addr))
		else $error("dspRam write with unknown address");

endmodule

// File: logic/dspSequencer.sv
module dspSequencer import dspPkg::*; (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic                run,
	input  logic                pcLoad,
	input  logic [prgAddrW-1:0] pcLoadValue,
	input  logic                prgWrEn,
	input  logic [prgAddrW-1:0] xferAddr,
	input  logic [wordW-1:0]    xferData,
	input  logic                flagS,
	input  logic                flagZ,
	input  logic                flagC,
	input  logic [wordW-1:0]    d1Bus,
	output dspInstr             instr,
	output logic [prgAddrW-1:0] pc
);

	logic [prgAddrW-1:0] top;
	logic [loopW-1:0]    lop;
	logic                lpsActive;
	logic [wordW-1:0]    prgQ;
	logic [3:0]          flagVec;
	logic [3:0]          condHits;
	logic                isCtl;
	logic                cond;
	logic                jmpTaken;
	logic                btmTaken;
	logic                lpsStart;
	logic                lpsHold;
	logic                isEnd;

	dspRam #(.addrW(prgAddrW), .dataW(wordW)) iPrgRam (
		.CLK(CLK),
		.addr(run ? pc : xferAddr),
		.wrData(xferData),
		.wrEn(prgWrEn),
		.rdData(prgQ)
	);

	// Mask order is T0, C, S, Z; T0 has no DMA behind it
	assign flagVec = {1'b0, flagC, flagS, flagZ};
	assign condHits = instr.ctlView.condMask & flagVec;
	assign cond = instr.ctlView.condSense ? |condHits : ~|condHits;

	assign isCtl = run && instr.ctlView.cls == clsCtl;
	assign jmpTaken = isCtl && instr.ctlView.sub == kindJmp && cond;
	assign btmTaken = isCtl && instr.ctlView.sub == kindBtm && lop != '0;
	assign lpsStart = isCtl && instr.ctlView.sub == kindLps;
	assign isEnd = isCtl && instr.ctlView.sub inside {kindEnd, kindEndi};
	assign lpsHold = lpsActive && lop != '0;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pc <= '0;
			top <= '0;
			lop <= '0;
			lpsActive <= 1'b0;
			instr <= '0;
		end else begin
			if (run) begin
				pc <= pc + 1'b1;
				// Repeat the word after LPS until LOP runs out
				if (lpsActive) begin
					if (lop != '0) begin
						lop <= lop - 1'b1;
						pc <= pc;
					end else begin
						lpsActive <= 1'b0;
					end
				end
				if (lpsStart) begin
					lpsActive <= 1'b1;
				end
				if (btmTaken) begin
					lop <= lop - 1'b1;
					pc <= top;
				end
				if (jmpTaken) begin
					pc <= instr.ctlView.target;
				end
				if (d1Write(instr, dstPc)) begin
					pc <= d1Bus[prgAddrW-1:0];
					top <= pc;
				end
				if (d1Write(instr, dstLop)) begin
					lop <= d1Bus[loopW-1:0];
				end
				if (d1Write(instr, dstTop)) begin
					top <= d1Bus[prgAddrW-1:0];
				end
				if (isEnd) begin
					instr <= '0;
				end else if (!lpsHold) begin
					instr <= prgQ;
				end
			end else begin
				instr <= '0;
			end
			if (pcLoad) begin
				pc <= pcLoadValue;
			end
		end
	end

	assert property (@(posedge CLK) disable iff (!RST_N) prgWrEn |-> !run)
		else $error("Program RAM written while running");

endmodule

// File: logic/dspAlu.sv
module dspAlu import dspPkg::*; (
	input  logic            CLK,
	input  logic            RST_N,
	input  logic            run,
	input  dspInstr         instr,
	input  logic [accW-1:0] acc,
	input  logic [accW-1:0] prod,
	output logic [accW-1:0] aluResult,
	output logic            flagS,
	output logic            flagZ,
	output logic            flagC
);

	logic [wordW-1:0] lo;
	logic [wordW-1:0] pl;
	logic             carry;
	logic             valid;
	logic             wide;
	logic             update;

	assign lo = acc[wordW-1:0];
	assign pl = prod[wordW-1:0];

	// Upper half passes AC through except for AD2
	always_comb begin
		aluResult = acc;
		carry = 1'b0;
		valid = 1'b1;
		case (instr.opView.aluOp)
			aluAnd: aluResult[wordW-1:0] = lo & pl;
			aluOr:  aluResult[wordW-1:0] = lo | pl;
			aluXor: aluResult[wordW-1:0] = lo ^ pl;
			aluAdd: {carry, aluResult[wordW-1:0]} = {1'b0, lo} + {1'b0, pl};
			aluSub: {carry, aluResult[wordW-1:0]} = {1'b0, lo} - {1'b0, pl};
			aluAd2: {carry, aluResult} = {1'b0, acc} + {1'b0, prod};
			aluSr:  {aluResult[wordW-1:0], carry} = {lo[wordW-1], lo};
			aluRr:  {aluResult[wordW-1:0], carry} = {lo[0], lo};
			aluSl:  {carry, aluResult[wordW-1:0]} = {lo, 1'b0};
			aluRl:  {carry, aluResult[wordW-1:0]} = {lo, lo[wordW-1]};
			aluRl8: {carry, aluResult[wordW-1:0]} = {lo[24:0], lo[31:24]};
			aluNop: valid = 1'b0;
			default: valid = 1'b0;
		endcase
	end

	assign wide = instr.opView.aluOp == aluAd2;
	assign update = run && instr.opView.cls == clsOp && valid;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			flagS <= 1'b0;
			flagZ <= 1'b0;
			flagC <= 1'b0;
		end else if (update) begin
			flagS <= wide ? aluResult[accW-1] : aluResult[wordW-1];
			flagZ <= wide ? aluResult == '0 : aluResult[wordW-1:0] == '0;
			flagC <= carry;
		end
	end

endmodule

// File: logic/dspDatapath.sv
module dspDatapath import dspPkg::*; (
	input  logic             CLK,
	input  logic             RST_N,
	input  logic             run,
	input  dspInstr          instr,
	input  logic [accW-1:0]  aluResult,
	input  logic             dataWrEn,
	input  logic [7:0]       dataAddr,
	input  logic [wordW-1:0] xferData,
	output logic [accW-1:0]  acc,
	output logic [accW-1:0]  prod,
	output logic [wordW-1:0] d1Bus,
	output logic [wordW-1:0] dataRdWord
);

	dspOpCmd                  op;
	logic [wordW-1:0]         rx;
	logic [wordW-1:0]         ry;
	logic signed [2*wordW-1:0] mulFull;
	logic [bankAddrW-1:0]     ct [bankCount];
	logic [bankAddrW-1:0]     bankAddr [bankCount];
	logic [wordW-1:0]         bankD [bankCount];
	logic [wordW-1:0]         bankQ [bankCount];
	logic [bankCount-1:0]     bankWe;
	logic [bankCount-1:0]     d1RamWr;
	logic [bankCount-1:0]     ctWr;
	logic [bankCount-1:0]     ctInc;
	logic [wordW-1:0]         xBus;
	logic [wordW-1:0]         yBus;
	logic                     isOp;
	logic                     xRead;
	logic                     yRead;

	function automatic logic [accW-1:0] sext(input logic [wordW-1:0] w);
		return {{(accW - wordW){w[wordW-1]}}, w};
	endfunction

	assign op = instr.opView;
	assign isOp = run && op.cls == clsOp;
	assign xRead = op.xOp inside {xRx, xPRam};
	assign yRead = op.yOp inside {yRy, yAcRam};
	assign mulFull = $signed(rx) * $signed(ry);

	assign xBus = bankQ[op.xSrc];
	assign yBus = bankQ[op.ySrc];
	assign dataRdWord = bankQ[dataAddr[7:6]];

	always_comb begin
		d1Bus = '0;
		if (instr.ctlView.cls == clsMvi) begin
			d1Bus = mviImm(instr);
		end else if (op.cls == clsOp && op.d1En) begin
			case (op.d1Src)
				srcImm:  d1Bus = {{(wordW - 9){op.d1Imm[8]}}, op.d1Imm};
				srcAluL: d1Bus = aluResult[wordW-1:0];
				srcAluH: d1Bus = aluResult[accW-1:accW-wordW];
				default: begin
					if (op.d1Src[2]) begin
						d1Bus = bankQ[op.d1Src[1:0]];
					end
				end
			endcase
		end
	end

	// Any bank touched by this word steps its counter afterwards
	always_comb begin
		d1RamWr = '0;
		ctWr = '0;
		ctInc = '0;
		for (int b = 0; b < bankCount; b++) begin
			d1RamWr[b] = run && d1Write(instr, dstRam0 + 4'(b));
			ctWr[b] = run && d1Write(instr, dstCt0 + 4'(b));
			ctInc[b] = d1RamWr[b] || (isOp && ((xRead && op.xSrc == 2'(b)) ||
				(yRead && op.ySrc == 2'(b)) ||
				(op.d1En && op.d1Src == srcRam0 + 3'(b))));
		end
	end

	for (genvar b = 0; b < bankCount; b++) begin : gBank
		assign bankAddr[b] = run ? ct[b] : dataAddr[bankAddrW-1:0];
		assign bankWe[b] = run ? d1RamWr[b] : dataWrEn && dataAddr[7:6] == 2'(b);
		assign bankD[b] = run ? d1Bus : xferData;

		dspRam #(.addrW(bankAddrW), .dataW(wordW)) iBankRam (
			.CLK(CLK),
			.addr(bankAddr[b]),
			.wrData(bankD[b]),
			.wrEn(bankWe[b]),
			.rdData(bankQ[b])
		);
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int b = 0; b < bankCount; b++) begin
				ct[b] <= '0;
			end
		end else begin
			for (int b = 0; b < bankCount; b++) begin
				if (ctInc[b]) begin
					ct[b] <= ct[b] + 1'b1;
				end
				if (ctWr[b]) begin
					ct[b] <= d1Bus[bankAddrW-1:0];
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (isOp) begin
			case (op.xOp)
				xRx:   rx <= xBus;
				xPRam: prod <= sext(xBus);
				xPMul: prod <= mulFull[accW-1:0];
				xNone: ;
				default: ;
			endcase
			case (op.yOp)
				yRy:    ry <= yBus;
				yClrAc: acc <= '0;
				yAcAlu: acc <= aluResult;
				yAcRam: acc <= sext(yBus);
				yNone:  ;
				default: ;
			endcase
		end
		// D1 lands after the X bus
		if (run && d1Write(instr, dstRx)) begin
			rx <= d1Bus;
		end
		if (run && d1Write(instr, dstP)) begin
			prod <= sext(d1Bus);
		end
	end

	assert property (@(posedge CLK) disable iff (!RST_N) !(dataWrEn && |d1RamWr))
		else $error("Host and D1 write the data banks in the same cycle");

endmodule

// File: logic/dspHostPort.sv
module dspHostPort import dspPkg::*; (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic [1:0]          addr,
	input  logic [wordW-1:0]    wrData,
	input  logic                wrEn,
	input  logic                rdEn,
	input  dspInstr             instr,
	input  logic [prgAddrW-1:0] pc,
	input  logic                flagS,
	input  logic                flagZ,
	input  logic                flagC,
	input  logic [wordW-1:0]    dataRdWord,
	output logic [wordW-1:0]    rdData,
	output logic                run,
	output logic                pcLoad,
	output logic [prgAddrW-1:0] pcLoadValue,
	output logic                prgWrEn,
	output logic [prgAddrW-1:0] xferAddr,
	output logic [wordW-1:0]    xferData,
	output logic                dataWrEn,
	output logic [7:0]          dataAddr,
	output logic                irq
);

	logic             ex;
	logic             e;
	logic             stepReq;
	logic             ctlWr;
	logic             dataRd;
	logic             execEnd;
	logic             execEndi;
	logic [wordW-1:0] status;

	assign ctlWr = wrEn && addr == regCtl;
	assign prgWrEn = wrEn && addr == regPrg;
	assign dataWrEn = wrEn && addr == regData;
	assign dataRd = rdEn && addr == regData;
	assign pcLoad = ctlWr && wrData[ctlLoadPc];
	assign pcLoadValue = wrData[prgAddrW-1:0];
	assign xferData = wrData;

	assign run = ex || stepReq;
	assign irq = e;

	assign execEnd = run && instr.ctlView.cls == clsCtl &&
		instr.ctlView.sub inside {kindEnd, kindEndi};
	assign execEndi = execEnd && instr.ctlView.sub == kindEndi;

	always_comb begin
		status = '0;
		status[statS] = flagS;
		status[statZ] = flagZ;
		status[statC] = flagC;
		status[statE] = e;
		status[statEx] = ex;
		status[prgAddrW-1:0] = pc;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ex <= 1'b0;
			e <= 1'b0;
			stepReq <= 1'b0;
			xferAddr <= '0;
			dataAddr <= '0;
			rdData <= '0;
		end else begin
			// Step request lasts one executing cycle
			if (run) begin
				stepReq <= 1'b0;
			end
			// Any control write also rewinds the program transfer address
			if (ctlWr) begin
				ex <= wrData[statEx];
				xferAddr <= wrData[prgAddrW-1:0];
				if (!ex && wrData[ctlStep]) begin
					stepReq <= 1'b1;
				end
			end
			if (prgWrEn) begin
				xferAddr <= xferAddr + 1'b1;
			end
			if (wrEn && addr == regDataAddr) begin
				dataAddr <= wrData[7:0];
			end
			if (dataWrEn || dataRd) begin
				dataAddr <= dataAddr + 1'b1;
			end
			if (rdEn) begin
				case (addr)
					regCtl:  rdData <= status;
					regData: rdData <= dataRdWord;
					default: rdData <= '0;
				endcase
				if (addr == regCtl) begin
					e <= 1'b0;
				end
			end
			if (execEnd) begin
				ex <= 1'b0;
			end
			if (execEndi) begin
				e <= 1'b1;
			end
		end
	end

	assert property (@(posedge CLK) disable iff (!RST_N) (prgWrEn || dataWrEn || dataRd) |-> !ex)
		else $error("Host RAM access while EX is set");

endmodule

// File: logic/scuDsp.sv
module scuDsp import dspPkg::*; (
	input  logic             CLK,
	input  logic             RST_N,
	input  logic [1:0]       addr,
	input  logic [wordW-1:0] wrData,
	input  logic             wrEn,
	input  logic             rdEn,
	output logic [wordW-1:0] rdData,
	output logic             irq
);

	logic                run;
	logic                pcLoad;
	logic [prgAddrW-1:0] pcLoadValue;
	logic                prgWrEn;
	logic [prgAddrW-1:0] xferAddr;
	logic [wordW-1:0]    xferData;
	logic                dataWrEn;
	logic [7:0]          dataAddr;
	dspInstr             instr;
	logic [prgAddrW-1:0] pc;
	logic [accW-1:0]     aluResult;
	logic                flagS;
	logic                flagZ;
	logic                flagC;
	logic [accW-1:0]     acc;
	logic [accW-1:0]     prod;
	logic [wordW-1:0]    d1Bus;
	logic [wordW-1:0]    dataRdWord;

	dspHostPort iHostPort (
		.CLK(CLK),
		.RST_N(RST_N),
		.addr(addr),
		.wrData(wrData),
		.wrEn(wrEn),
		.rdEn(rdEn),
		.instr(instr),
		.pc(pc),
		.flagS(flagS),
		.flagZ(flagZ),
		.flagC(flagC),
		.dataRdWord(dataRdWord),
		.rdData(rdData),
		.run(run),
		.pcLoad(pcLoad),
		.pcLoadValue(pcLoadValue),
		.prgWrEn(prgWrEn),
		.xferAddr(xferAddr),
		.xferData(xferData),
		.dataWrEn(dataWrEn),
		.dataAddr(dataAddr),
		.irq(irq)
	);

	dspSequencer iSequencer (
		.CLK(CLK),
		.RST_N(RST_N),
		.run(run),
		.pcLoad(pcLoad),
		.pcLoadValue(pcLoadValue),
		.prgWrEn(prgWrEn),
		.xferAddr(xferAddr),
		.xferData(xferData),
		.flagS(flagS),
		.flagZ(flagZ),
		.flagC(flagC),
		.d1Bus(d1Bus),
		.instr(instr),
		.pc(pc)
	);

	dspAlu iAlu (
		.CLK(CLK),
		.RST_N(RST_N),
		.run(run),
		.instr(instr),
		.acc(acc),
		.prod(prod),
		.aluResult(aluResult),
		.flagS(flagS),
		.flagZ(flagZ),
		.flagC(flagC)
	);

	dspDatapath iDatapath (
		.CLK(CLK),
		.RST_N(RST_N),
		.run(run),
		.instr(instr),
		.aluResult(aluResult),
		.dataWrEn(dataWrEn),
		.dataAddr(dataAddr),
		.xferData(xferData),
		.acc(acc),
		.prod(prod),
		.d1Bus(d1Bus),
		.dataRdWord(dataRdWord)
	);

endmodule

// File: testbench/scuDspTb.sv
module scuDspTb import dspPkg::*;;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int cycleLimit = 6000;

	logic             CLK;
	logic             RST_N;
	logic [1:0]       addr;
	logic [wordW-1:0] wrData;
	logic             wrEn;
	logic             rdEn;
	logic [wordW-1:0] rdData;
	logic             irq;

	logic             chkRd;
	logic [wordW-1:0] expRd;
	logic             chkIrq;
	logic             expIrq;
	int               cycles;
	logic [wordW-1:0] bankModel [256];
	logic [wordW-1:0] prog [$];

	scuDsp i_dut (
		.CLK(CLK),
		.RST_N(RST_N),
		.addr(addr),
		.wrData(wrData),
		.wrEn(wrEn),
		.rdEn(rdEn),
		.rdData(rdData),
		.irq(irq)
	);

	always #5 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Run timed out after %0d cycles", cycles);
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic valueMismatch(string name, logic [wordW-1:0] exp, logic [wordW-1:0] act);
		$display("FAIL %s expected %h actual %h", name, exp, act);
		$display("TESTBENCH FAILED");
		$fatal(1, "value mismatch");
	endtask

	// rdData was captured one edge before the check
	assert property (@(posedge CLK) chkRd |-> rdData == expRd)
		else valueMismatch("rdData", $sampled(expRd), $sampled(rdData));

	assert property (@(posedge CLK) chkIrq |-> irq == expIrq)
		else valueMismatch("irq", 32'($sampled(expIrq)), 32'($sampled(irq)));

	function automatic logic [wordW-1:0] opWord(logic [3:0] alu, logic [1:0] xo, logic [1:0] xs,
		logic [2:0] yo, logic [1:0] ys, logic d1, logic [2:0] src, logic [3:0] dst,
		logic [8:0] imm);
		dspInstr w;
		w = '0;
		w.opView.cls = clsOp;
		w.opView.aluOp = alu;
		w.opView.xOp = xo;
		w.opView.xSrc = xs;
		w.opView.yOp = yo;
		w.opView.ySrc = ys;
		w.opView.d1En = d1;
		w.opView.d1Src = src;
		w.opView.d1Dst = dst;
		w.opView.d1Imm = imm;
		return w;
	endfunction

	function automatic logic [wordW-1:0] mviWord(logic [3:0] dst, logic [24:0] imm);
		dspInstr w;
		w = '0;
		w.ctlView.cls = clsMvi;
		w.ctlView.sub = dst;
		{w.ctlView.condMask, w.ctlView.immMid, w.ctlView.target} = imm;
		return w;
	endfunction

	function automatic logic [wordW-1:0] ctlWord(logic [3:0] kind, logic sense, logic [3:0] mask,
		logic [7:0] target);
		dspInstr w;
		w = '0;
		w.ctlView.cls = clsCtl;
		w.ctlView.sub = kind;
		w.ctlView.condSense = sense;
		w.ctlView.condMask = mask;
		w.ctlView.target = target;
		return w;
	endfunction

	function automatic logic [wordW-1:0] storeImm(int bank, logic [8:0] imm);
		return opWord(aluNop, xNone, 2'd0, yNone, 2'd0, 1'b1, srcImm, dstRam0 + 4'(bank), imm);
	endfunction

	task automatic busWrite(logic [1:0] a, logic [wordW-1:0] d);
		addr = a;
		wrData = d;
		wrEn = 1'b1;
		@(negedge CLK);
		wrEn = 1'b0;
	endtask

	task automatic busRead(logic [1:0] a, logic chk, logic [wordW-1:0] exp);
		addr = a;
		rdEn = 1'b1;
		@(negedge CLK);
		rdEn = 1'b0;
		expRd = exp;
		chkRd = chk;
	endtask

	task automatic hostStore(logic [7:0] base, logic [wordW-1:0] d);
		busWrite(regDataAddr, 32'(base));
		busWrite(regData, d);
		bankModel[base] = d;
	endtask

	task automatic checkRegion(logic [7:0] base, int count);
		busWrite(regDataAddr, 32'(base));
		for (int i = 0; i < count; i++) begin
			busRead(regData, 1'b1, bankModel[8'(base + i)]);
		end
	endtask

	// Loads PC 0 then streams the program and starts it
	task automatic runProgram();
		busWrite(regCtl, 32'(1) << ctlLoadPc);
		foreach (prog[i]) begin
			busWrite(regPrg, prog[i]);
		end
		busWrite(regCtl, 32'(1) << statEx);
		while (!irq) begin
			@(negedge CLK);
		end
		// irq holds until the status read
		expIrq = 1'b1;
		chkIrq = 1'b1;
	endtask

	task automatic statusCheck(logic chk, logic [wordW-1:0] exp);
		busRead(regCtl, chk, exp);
		expIrq = 1'b0;
		chkIrq = 1'b1;
		repeat (2) @(negedge CLK);
		chkIrq = 1'b0;
	endtask

	initial begin
		logic [wordW-1:0] a;
		logic [wordW-1:0] b;
		logic [wordW-1:0] res;
		logic [wordW-1:0] xv [4];
		logic [wordW-1:0] yv [4];
		logic signed [63:0] prodFull;
		logic [accW-1:0] accModel;
		logic [3:0] ops [11];
		logic fs;
		logic fz;
		logic fc;
		int n;
		int k;

		void'($urandom(32'h8eb9e10b));
		CLK = 1'b0;
		RST_N = 1'b0;
		addr = '0;
		wrData = '0;
		wrEn = 1'b0;
		rdEn = 1'b0;
		chkRd = 1'b0;
		expRd = '0;
		chkIrq = 1'b0;
		expIrq = 1'b0;
		cycles = 0;
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;
		chkIrq = 1'b1;

		// Transfer across all four banks
		busWrite(regDataAddr, 32'h0);
		for (int i = 0; i < 256; i++) begin
			bankModel[i] = $urandom();
			busWrite(regData, bankModel[i]);
		end
		chkIrq = 1'b0;
		checkRegion(8'h00, 256);

		// ALU on AC = a and P = b
		a = $urandom();
		b = $urandom();
		hostStore(8'h00, a);
		hostStore(8'h01, b);
		ops = '{aluAnd, aluOr, aluXor, aluAdd, aluSub, aluAd2, aluSr, aluRr, aluSl, aluRl, aluRl8};
		prog = {};
		prog.push_back(mviWord(dstCt0, 25'd0));
		prog.push_back(mviWord(dstCt0 + 4'd1, 25'd0));
		prog.push_back(opWord(aluNop, xNone, 2'd0, yAcRam, 2'd0, 1'b0, srcImm, 4'd0, 9'd0));
		prog.push_back(opWord(aluNop, xPRam, 2'd0, yNone, 2'd0, 1'b0, srcImm, 4'd0, 9'd0));
		for (int i = 0; i < 11; i++) begin
			prog.push_back(opWord(ops[i], xNone, 2'd0, yNone, 2'd0, 1'b1, srcAluL,
				dstRam0 + 4'd1, 9'd0));
			case (ops[i])
				aluAnd: res = a & b;
				aluOr:  res = a | b;
				aluXor: res = a ^ b;
				aluAdd: res = a + b;
				aluSub: res = a - b;
				aluAd2: res = a + b;
				aluSr:  res = {a[31], a[31:1]};
				aluRr:  res = {a[0], a[31:1]};
				aluSl:  res = {a[30:0], 1'b0};
				aluRl:  res = {a[30:0], a[31]};
				default: res = {a[23:0], a[31:24]};
			endcase
			bankModel[64 + i] = res;
		end
		prog.push_back(ctlWord(kindEndi, 1'b0, 4'd0, 8'd0));
		runProgram();
		// RL8 is last so C is the last bit rotated out
		fs = res[31];
		fz = res == '0;
		fc = a[24];
		statusCheck(1'b1, (32'(fs) << statS) | (32'(fz) << statZ) | (32'(fc) << statC) |
			(32'(1) << statE) | 32'(prog.size() + 1));
		checkRegion(8'h40, 11);

		// Multiply-accumulate over four products
		accModel = '0;
		for (int i = 0; i < 4; i++) begin
			xv[i] = $urandom();
			yv[i] = $urandom();
			hostStore(8'(128 + i), xv[i]);
			hostStore(8'(192 + i), yv[i]);
			prodFull = $signed(xv[i]) * $signed(yv[i]);
			accModel = accModel + prodFull[accW-1:0];
		end
		bankModel[80] = accModel[47:16];
		bankModel[81] = accModel[31:0];
		prog = {};
		prog.push_back(mviWord(dstCt0 + 4'd2, 25'd0));
		prog.push_back(mviWord(dstCt0 + 4'd3, 25'd0));
		prog.push_back(mviWord(dstCt0 + 4'd1, 25'd16));
		prog.push_back(opWord(aluNop, xNone, 2'd0, yClrAc, 2'd0, 1'b0, srcImm, 4'd0, 9'd0));
		for (int i = 0; i < 4; i++) begin
			prog.push_back(opWord(aluNop, xRx, 2'd2, yRy, 2'd3, 1'b0, srcImm, 4'd0, 9'd0));
			prog.push_back(opWord(aluNop, xPMul, 2'd0, yNone, 2'd0, 1'b0, srcImm, 4'd0, 9'd0));
			prog.push_back(opWord(aluAd2, xNone, 2'd0, yAcAlu, 2'd0, 1'b0, srcImm, 4'd0, 9'd0));
		end
		prog.push_back(opWord(aluNop, xNone, 2'd0, yNone, 2'd0, 1'b1, srcAluH,
			dstRam0 + 4'd1, 9'd0));
		prog.push_back(opWord(aluNop, xNone, 2'd0, yNone, 2'd0, 1'b1, srcAluL,
			dstRam0 + 4'd1, 9'd0));
		prog.push_back(ctlWord(kindEndi, 1'b0, 4'd0, 8'd0));
		runProgram();
		statusCheck(1'b0, '0);
		checkRegion(8'h50, 2);

		// LPS repeat and then a BTM block with its delay slot
		n = $urandom_range(6, 2);
		for (int i = 0; i <= n; i++) begin
			bankModel[i] = 32'h55;
		end
		k = 104;
		for (int i = 0; i <= 2; i++) begin
			bankModel[k] = 32'hAA;
			bankModel[k + 1] = 32'hBB;
			k = k + 2;
		end
		prog = {};
		prog.push_back(mviWord(dstCt0, 25'd0));
		prog.push_back(mviWord(dstLop, 25'(n)));
		prog.push_back(ctlWord(kindLps, 1'b0, 4'd0, 8'd0));
		prog.push_back(storeImm(0, 9'h55));
		prog.push_back(mviWord(dstCt0 + 4'd1, 25'd40));
		prog.push_back(mviWord(dstLop, 25'd2));
		prog.push_back(mviWord(dstTop, 25'd7));
		prog.push_back(storeImm(1, 9'hAA));
		prog.push_back(ctlWord(kindBtm, 1'b0, 4'd0, 8'd0));
		prog.push_back(storeImm(1, 9'hBB));
		prog.push_back(ctlWord(kindEndi, 1'b0, 4'd0, 8'd0));
		runProgram();
		statusCheck(1'b0, '0);
		checkRegion(8'h00, n + 2);
		checkRegion(8'h68, 7);

		// Jumps on Z and C with mask order T0 C S Z
		prog = {};
		prog.push_back(mviWord(dstCt0, 25'd48));
		prog.push_back(mviWord(dstP, 25'd0));
		prog.push_back(opWord(aluNop, xNone, 2'd0, yClrAc, 2'd0, 1'b0, srcImm, 4'd0, 9'd0));
		prog.push_back(opWord(aluAdd, xNone, 2'd0, yNone, 2'd0, 1'b0, srcImm, 4'd0, 9'd0));
		prog.push_back(ctlWord(kindJmp, 1'b1, 4'b0001, 8'd7));
		prog.push_back(storeImm(0, 9'd1));
		prog.push_back(storeImm(0, 9'd2));
		prog.push_back(storeImm(0, 9'd3));
		prog.push_back(ctlWord(kindJmp, 1'b1, 4'b0100, 8'd11));
		prog.push_back(storeImm(0, 9'd4));
		prog.push_back(storeImm(0, 9'd5));
		prog.push_back(ctlWord(kindJmp, 1'b0, 4'b0100, 8'd14));
		prog.push_back(storeImm(0, 9'd6));
		prog.push_back(storeImm(0, 9'd7));
		prog.push_back(storeImm(0, 9'd8));
		prog.push_back(ctlWord(kindJmp, 1'b0, 4'b0001, 8'd18));
		prog.push_back(storeImm(0, 9'd9));
		prog.push_back(storeImm(0, 9'd10));
		prog.push_back(ctlWord(kindEndi, 1'b0, 4'd0, 8'd0));
		bankModel[48] = 32'd1;
		bankModel[49] = 32'd3;
		bankModel[50] = 32'd4;
		bankModel[51] = 32'd5;
		bankModel[52] = 32'd6;
		bankModel[53] = 32'd8;
		bankModel[54] = 32'd9;
		bankModel[55] = 32'd10;
		runProgram();
		// ENDI at 18 leaves PC at 20 and EX clear
		statusCheck(1'b1, (32'(1) << statZ) | (32'(1) << statE) | 32'd20);
		checkRegion(8'h30, 9);

		// Single step from PC 5 moves PC to 6
		busWrite(regCtl, (32'(1) << ctlStep) | (32'(1) << ctlLoadPc) | 32'd5);
		repeat (3) @(negedge CLK);
		statusCheck(1'b1, (32'(1) << statZ) | 32'd6);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: src.f
logic/dspPkg.sv
logic/dspRam.sv
logic/dspSequencer.sv
logic/dspAlu.sv
logic/dspDatapath.sv
logic/dspHostPort.sv
logic/scuDsp.sv
testbench/scuDspTb.sv
